/* eeprom_system.f */
+incdir+src
src/eeprom_pkg.sv
src/eeprom_cmd_reg.sv
src/eeprom_wr.sv
src/eeprom_slave.sv
src/eeprom_system.sv
sim/tb_eeprom_system.sv

/* Makefile */
TOP   = tb_eeprom_system
FLIST = eeprom_system.f

.PHONY: lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f $(FLIST) --top-module eeprom_system

obj_dir/V$(TOP): $(FLIST) src/*.sv src/*.svh sim/*.sv
	verilator --binary --timing --assert -f $(FLIST) --top-module $(TOP) -Mdir obj_dir

sim: obj_dir/V$(TOP)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "PASS: all tests"

clean:
	rm -rf obj_dir

/* sim/tb_eeprom_system.sv */
`timescale 1ns/1ps
`include "eeprom_config.svh"

module tb_eeprom_system;

    localparam int N_TRANS     = 90;
    localparam int CYCLE_LIMIT = N_TRANS * 120 + 200;

    logic                      CLK;
    logic                      RESET;
    logic                      wr;
    logic                      rd;
    logic [`EEPROM_ADDR_W-1:0] addr;
    logic [`EEPROM_DATA_W-1:0] wr_data;
    logic                      busy;
    logic                      ack;
    logic [`EEPROM_DATA_W-1:0] rd_data;

    logic [`EEPROM_DATA_W-1:0] shadow [0:`EEPROM_DEPTH-1];
    logic [`EEPROM_ADDR_W-1:0] rand_addr [0:39];
    logic [`EEPROM_ADDR_W-1:0] pend_addr;
    int                        read_seq;
    int                        seen_seq;
    int                        errors;
    int                        read_errors;
    int                        test_errs;
    int                        accepted;
    int                        ack_count;
    int                        tests_run;
    int                        cycles;
    integer                    seed;

    eeprom_system u_eeprom_system (
        .CLK(CLK), .RESET(RESET), .wr(wr), .rd(rd), .addr(addr), .wr_data(wr_data),
        .busy(busy), .ack(ack), .rd_data(rd_data)
    );

    initial begin
        CLK = 1'b0;
        forever #4 CLK = ~CLK;
    end

    // expected byte is whatever the last accepted write left there
    function automatic logic [`EEPROM_DATA_W-1:0] expected_read(
        input logic [`EEPROM_ADDR_W-1:0] a);
        return shadow[a];
    endfunction

    task automatic check(input logic [31:0] actual, input logic [31:0] expected,
                         input string msg, inout int errs);
        if (actual !== expected) begin
            errs++;
            $display("Mismatch at time %0t: %s, got %0h, expected %0h",
                     $time, msg, actual, expected);
        end
    endtask

    // one-cycle strobe, then busy must be up
    task automatic issue(input logic is_read, input logic [`EEPROM_ADDR_W-1:0] a,
                         input logic [`EEPROM_DATA_W-1:0] d);
        @(posedge CLK);
        #1;
        check(32'(busy), 32'd0, "busy before strobe", errors);
        wr      = ~is_read;
        rd      = is_read;
        addr    = a;
        wr_data = d;
        if (is_read) begin
            pend_addr = a;
            read_seq++;
        end else begin
            shadow[a] = d;
        end
        accepted++;
        @(posedge CLK);
        #1;
        wr = 1'b0;
        rd = 1'b0;
        check(32'(busy), 32'd1, "busy after accepted strobe", errors);
    endtask

    task automatic wait_ack();
        logic busy_prev;

        busy_prev = busy;
        while (ack !== 1'b1) begin
            busy_prev = busy;
            @(posedge CLK);
            #1;
        end
        check(32'(busy_prev), 32'd0, "busy low the cycle before ack", errors);
        check(32'(busy), 32'd0, "busy low at ack", errors);
    endtask

    task automatic do_write(input logic [`EEPROM_ADDR_W-1:0] a,
                            input logic [`EEPROM_DATA_W-1:0] d);
        issue(1'b0, a, d);
        wait_ack();
    endtask

    task automatic do_read(input logic [`EEPROM_ADDR_W-1:0] a);
        issue(1'b1, a, '0);
        wait_ack();
    endtask

    task automatic report_test(input string name);
        @(posedge CLK);  // last ack of the test is compared on the falling edge
        #1;
        tests_run++;
        $display("test %0d %s: %0d errors", tests_run, name,
                 errors + read_errors - test_errs);
        test_errs = errors + read_errors;
    endtask

    // compare on the falling edge, where ack and rd_data are settled
    initial begin
        ack_count   = 0;
        seen_seq    = 0;
        read_errors = 0;
        forever begin
            @(negedge CLK);
            if (!RESET && ack) begin
                ack_count++;
                if (seen_seq != read_seq) begin
                    check(32'(rd_data), 32'(expected_read(pend_addr)), "read data",
                          read_errors);
                    seen_seq = read_seq;
                end
            end
        end
    end

    initial begin
        cycles = 0;
        while (cycles < CYCLE_LIMIT) begin
            @(posedge CLK);
            cycles++;
        end
        $display("timeout: the tests did not finish within %0d cycles", CYCLE_LIMIT);
        $display("FAIL: see errors above");
        $finish;
    end

    initial begin
        logic [31:0]               r;
        logic [`EEPROM_ADDR_W-1:0] a;
        logic [`EEPROM_DATA_W-1:0] d;
        logic [`EEPROM_DATA_W-1:0] held;

        RESET     = 1'b1;
        wr        = 1'b0;
        rd        = 1'b0;
        addr      = '0;
        wr_data   = '0;
        pend_addr = '0;
        read_seq  = 0;
        errors    = 0;
        test_errs = 0;
        accepted  = 0;
        tests_run = 0;
        seed      = 32'h15c1_d8cf;
        repeat (3) @(posedge CLK);
        #1;
        RESET = 1'b0;

        check(32'(busy), 32'd0, "busy after reset", errors);
        check(32'(ack), 32'd0, "ack after reset", errors);
        check(32'(rd_data), 32'd0, "rd_data after reset", errors);
        report_test("reset state");

        do_write(11'h5a3, 8'h3c);
        do_read(11'h5a3);
        report_test("write then read back");

        // block number in bits 10..8 walks all eight blocks
        for (int i = 0; i < 40; i++) begin
            r = $random(seed);
            if (i == 39) begin
                a = rand_addr[5];  // overwrite an earlier address
                d = ~shadow[a];
            end else begin
                a = {3'(i % 8), r[7:0]};
                d = r[15:8];
            end
            rand_addr[i] = a;
            do_write(a, d);
        end
        for (int i = 0; i < 40; i++) begin
            do_read(rand_addr[i]);
        end
        report_test("random traffic");

        issue(1'b0, 11'h0f0, 8'h81);
        repeat (5) @(posedge CLK);
        #1;
        check(32'(busy), 32'd1, "busy during transfer", errors);
        wr      = 1'b1;  // must be dropped
        addr    = 11'h5a3;
        wr_data = ~shadow[11'h5a3];
        @(posedge CLK);
        #1;
        wr = 1'b0;
        wait_ack();
        do_read(11'h5a3);
        @(posedge CLK);
        #1;
        check(32'(ack_count), 32'(accepted), "ack count after ignored strobe", errors);
        report_test("request while busy");

        do_read(rand_addr[12]);
        held = expected_read(rand_addr[12]);
        for (int i = 0; i < 4; i++) begin
            r = $random(seed);
            do_write({3'(i * 2), r[7:0]}, r[15:8]);
            check(32'(rd_data), 32'(held), "rd_data held across write", errors);
        end
        do_read(rand_addr[30]);
        report_test("write keeps rd_data");

        @(posedge CLK);
        #1;
        check(32'(ack_count), 32'(accepted), "one ack per accepted strobe", errors);
        $display("tests %0d, transactions %0d, acks %0d, errors %0d",
                 tests_run, accepted, ack_count, errors + read_errors);
        if (errors + read_errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

/* src/eeprom_system.sv */
`timescale 1ns/1ps
`include "eeprom_config.svh"

module eeprom_system (
    input  logic                      CLK,
    input  logic                      RESET,
    input  logic                      wr,
    input  logic                      rd,
    input  logic [`EEPROM_ADDR_W-1:0] addr,
    input  logic [`EEPROM_DATA_W-1:0] wr_data,
    output logic                      busy,
    output logic                      ack,
    output logic [`EEPROM_DATA_W-1:0] rd_data
);

    eeprom_pkg::op_e           op;
    logic [`EEPROM_ADDR_W-1:0] cmd_addr;
    logic [`EEPROM_DATA_W-1:0] cmd_data;
    logic [`EEPROM_DATA_W-1:0] rx_byte;
    logic                      go;
    logic                      done;
    logic                      scl;
    logic                      sda;
    logic                      m_sda_low;
    logic                      s_sda_low;

    assign sda = ~(m_sda_low | s_sda_low);  // pulled up unless someone pulls low

    eeprom_cmd_reg u_cmd_reg (
        .CLK(CLK), .RESET(RESET), .wr(wr), .rd(rd), .addr(addr), .wr_data(wr_data),
        .done(done), .rx_byte(rx_byte), .busy(busy), .ack(ack), .rd_data(rd_data),
        .go(go), .op(op), .cmd_addr(cmd_addr), .cmd_data(cmd_data)
    );

    eeprom_wr u_eeprom_wr (
        .CLK(CLK), .RESET(RESET), .go(go), .op(op), .cmd_addr(cmd_addr),
        .cmd_data(cmd_data), .sda(sda), .scl(scl), .m_sda_low(m_sda_low),
        .done(done), .rx_byte(rx_byte), .nack_err()
    );

    eeprom_slave u_eeprom_slave (
        .CLK(CLK), .RESET(RESET), .scl(scl), .sda(sda), .s_sda_low(s_sda_low)
    );

endmodule

/* src/eeprom_slave.sv */
`timescale 1ns/1ps
`include "eeprom_config.svh"

module eeprom_slave (
    input  logic CLK,
    input  logic RESET,
    input  logic scl,
    input  logic sda,
    output logic s_sda_low
);

    eeprom_pkg::slave_state_e  state;
    eeprom_pkg::slave_state_e  after_ack;
    logic [`EEPROM_DATA_W-1:0] mem [0:`EEPROM_DEPTH-1];
    logic [`EEPROM_DATA_W-1:0] shreg;
    logic [`EEPROM_DATA_W-1:0] rx_next;
    logic [`EEPROM_ADDR_W-1:0] mem_addr;
    logic [3:0]                bit_cnt;
    logic                      scl_q;
    logic                      sda_q;
    logic                      rise;
    logic                      fall;
    logic                      start_c;
    logic                      stop_c;

    assign rise    = scl & ~scl_q;
    assign fall    = ~scl & scl_q;
    // an sda edge after a high scl sample is a start or stop
    assign start_c = scl_q & sda_q & ~sda;
    assign stop_c  = scl_q & ~sda_q & sda;
    assign rx_next = {shreg[`EEPROM_DATA_W-2:0], sda};

    always_ff @(posedge CLK) begin
        if (RESET) begin
            scl_q     <= 1'b0;
            sda_q     <= 1'b1;
            state     <= eeprom_pkg::sl_idle;
            bit_cnt   <= '0;
            s_sda_low <= 1'b0;
        end else begin
            scl_q <= scl;
            sda_q <= sda;
            if (start_c) begin
                state     <= eeprom_pkg::sl_get_ctrl;
                bit_cnt   <= '0;
                s_sda_low <= 1'b0;
            end else if (stop_c) begin
                state     <= eeprom_pkg::sl_idle;
                s_sda_low <= 1'b0;
            end else begin
                case (state)
                    eeprom_pkg::sl_get_ctrl, eeprom_pkg::sl_get_addr,
                    eeprom_pkg::sl_get_data: begin
                        if (rise) begin
                            shreg   <= rx_next;
                            bit_cnt <= bit_cnt + 4'd1;
                            if (bit_cnt == 4'd7) begin
                                state <= eeprom_pkg::sl_ack_out;
                                case (state)
                                    eeprom_pkg::sl_get_ctrl: begin
                                        if (rx_next[7:4] != `EEPROM_DEV_CODE) begin
                                            state <= eeprom_pkg::sl_idle;  // not ours
                                        end else if (rx_next[0]) begin
                                            after_ack <= eeprom_pkg::sl_send_data;
                                        end else begin
                                            mem_addr[`EEPROM_ADDR_W-1:`EEPROM_DATA_W] <=
                                                rx_next[3:1];
                                            after_ack <= eeprom_pkg::sl_get_addr;
                                        end
                                    end
                                    eeprom_pkg::sl_get_addr: begin
                                        mem_addr[`EEPROM_DATA_W-1:0] <= rx_next;
                                        after_ack <= eeprom_pkg::sl_get_data;
                                    end
                                    default: begin
                                        mem[mem_addr] <= rx_next;  // committed at once
                                        after_ack     <= eeprom_pkg::sl_idle;
                                    end
                                endcase
                            end
                        end
                    end
                    eeprom_pkg::sl_ack_out: begin
                        if (fall && !s_sda_low) begin
                            s_sda_low <= 1'b1;
                        end else if (fall) begin
                            state     <= after_ack;
                            bit_cnt   <= '0;
                            shreg     <= mem[mem_addr];
                            // read data starts right after the ack bit
                            s_sda_low <= (after_ack == eeprom_pkg::sl_send_data) ?
                                         ~mem[mem_addr][`EEPROM_DATA_W-1] : 1'b0;
                        end
                    end
                    eeprom_pkg::sl_send_data: begin
                        if (rise) begin
                            bit_cnt <= bit_cnt + 4'd1;
                        end else if (fall && bit_cnt == 4'd8) begin
                            s_sda_low <= 1'b0;
                            state     <= eeprom_pkg::sl_ack_in;
                        end else if (fall) begin
                            shreg     <= {shreg[`EEPROM_DATA_W-2:0], 1'b0};
                            s_sda_low <= ~shreg[`EEPROM_DATA_W-2];
                        end
                    end
                    eeprom_pkg::sl_ack_in: begin
                        if (rise) begin
                            state <= eeprom_pkg::sl_idle;  // single byte reads only
                        end
                    end
                    default: ;
                endcase
            end
        end
    end

    a_quiet_idle: assert property (@(posedge CLK) disable iff (RESET)
        state == eeprom_pkg::sl_idle |-> !s_sda_low);

endmodule

/* src/eeprom_wr.sv */
`timescale 1ns/1ps
`include "eeprom_config.svh"

module eeprom_wr (
    input  logic                      CLK,
    input  logic                      RESET,
    input  logic                      go,
    input  eeprom_pkg::op_e           op,
    input  logic [`EEPROM_ADDR_W-1:0] cmd_addr,
    input  logic [`EEPROM_DATA_W-1:0] cmd_data,
    input  logic                      sda,
    output logic                      scl,
    output logic                      m_sda_low,
    output logic                      done,
    output logic [`EEPROM_DATA_W-1:0] rx_byte,
    output logic                      nack_err
);

    eeprom_pkg::main_state_e   main_state;
    eeprom_pkg::main_state_e   after_ack;
    eeprom_pkg::bit_state_e    sub_state;
    logic [2:0]                bit_cnt;
    logic [1:0]                head_buf;
    logic [1:0]                stop_buf;
    logic [`EEPROM_DATA_W-1:0] sh8out_buf;
    logic [`EEPROM_DATA_W-1:0] tx_byte;
    logic [`EEPROM_DATA_W-1:0] ctrl_byte;
    logic                      link_sda;
    logic                      link_head;
    logic                      link_write;
    logic                      link_stop;

    // scl moves on the falling CLK edge so every rising edge sees a steady level
    always_ff @(negedge CLK) begin
        if (RESET) begin
            scl <= 1'b0;
        end else begin
            scl <= ~scl;
        end
    end

    assign ctrl_byte = {`EEPROM_DEV_CODE, cmd_addr[`EEPROM_ADDR_W-1:`EEPROM_DATA_W],
                        main_state == eeprom_pkg::main_ctrl_read};

    // the link enables select which buffer owns the line
    assign m_sda_low = link_sda & ~((link_head & head_buf[1]) |
                                    (link_write & sh8out_buf[`EEPROM_DATA_W-1]) |
                                    (link_stop & stop_buf[1]));

    always_comb begin
        case (main_state)
            eeprom_pkg::main_addr_write: tx_byte = cmd_addr[`EEPROM_DATA_W-1:0];
            eeprom_pkg::main_data_write: tx_byte = cmd_data;
            default:                     tx_byte = ctrl_byte;
        endcase
    end

    always_comb begin
        case (main_state)
            eeprom_pkg::main_ctrl_write: after_ack = eeprom_pkg::main_addr_write;
            eeprom_pkg::main_addr_write:
                after_ack = (op == eeprom_pkg::op_read) ? eeprom_pkg::main_read_start
                                                        : eeprom_pkg::main_data_write;
            eeprom_pkg::main_ctrl_read:  after_ack = eeprom_pkg::main_data_read;
            default:                     after_ack = eeprom_pkg::main_stop;
        endcase
    end

    always_ff @(posedge CLK) begin
        if (RESET) begin
            main_state <= eeprom_pkg::main_idle;
            sub_state  <= eeprom_pkg::seq_begin;
            bit_cnt    <= '0;
            link_sda   <= 1'b0;
            link_head  <= 1'b0;
            link_write <= 1'b0;
            link_stop  <= 1'b0;
            done       <= 1'b0;
            nack_err   <= 1'b0;
        end else begin
            done     <= 1'b0;
            nack_err <= 1'b0;
            case (main_state)
                eeprom_pkg::main_idle: begin
                    link_sda   <= 1'b0;
                    link_head  <= 1'b0;
                    link_write <= 1'b0;
                    link_stop  <= 1'b0;
                    main_state <= eeprom_pkg::main_ready;
                end
                eeprom_pkg::main_ready: begin
                    if (go) begin
                        main_state <= eeprom_pkg::main_write_start;
                        sub_state  <= eeprom_pkg::seq_begin;
                    end
                end
                eeprom_pkg::main_write_start, eeprom_pkg::main_read_start: begin
                    if (sub_state == eeprom_pkg::seq_begin && !scl) begin
                        head_buf   <= 2'b10;  // line high first
                        link_head  <= 1'b1;
                        link_write <= 1'b0;
                        link_sda   <= 1'b1;
                        sub_state  <= eeprom_pkg::seq_bit;
                    end else if (sub_state != eeprom_pkg::seq_begin && scl) begin
                        head_buf   <= {head_buf[0], 1'b0};  // falls while scl high
                        main_state <= (main_state == eeprom_pkg::main_write_start) ?
                                      eeprom_pkg::main_ctrl_write : eeprom_pkg::main_ctrl_read;
                        sub_state  <= eeprom_pkg::seq_begin;
                    end
                end
                eeprom_pkg::main_ctrl_write, eeprom_pkg::main_addr_write,
                eeprom_pkg::main_data_write, eeprom_pkg::main_ctrl_read: begin
                    case (sub_state)
                        eeprom_pkg::seq_begin: begin
                            if (!scl) begin
                                sh8out_buf <= tx_byte;
                                link_head  <= 1'b0;
                                link_write <= 1'b1;
                                link_sda   <= 1'b1;
                                bit_cnt    <= 3'd7;
                                sub_state  <= eeprom_pkg::seq_bit;
                            end
                        end
                        eeprom_pkg::seq_bit: begin
                            if (!scl && bit_cnt == 3'd0) begin
                                link_sda  <= 1'b0;  // let go for the ack bit
                                sub_state <= eeprom_pkg::seq_end;
                            end else if (!scl) begin
                                sh8out_buf <= {sh8out_buf[`EEPROM_DATA_W-2:0], 1'b0};
                                bit_cnt    <= bit_cnt - 3'd1;
                            end
                        end
                        default: begin
                            if (scl) begin
                                main_state <= sda ? eeprom_pkg::main_ackn : after_ack;
                                sub_state  <= eeprom_pkg::seq_begin;
                            end
                        end
                    endcase
                end
                eeprom_pkg::main_data_read: begin
                    case (sub_state)
                        eeprom_pkg::seq_begin: begin
                            if (!scl) begin
                                link_sda   <= 1'b0;
                                link_write <= 1'b0;
                                bit_cnt    <= 3'd7;
                                sub_state  <= eeprom_pkg::seq_bit;
                            end
                        end
                        eeprom_pkg::seq_bit: begin
                            if (scl) begin
                                rx_byte <= {rx_byte[`EEPROM_DATA_W-2:0], sda};
                                bit_cnt <= bit_cnt - 3'd1;
                                if (bit_cnt == 3'd0) begin
                                    sub_state <= eeprom_pkg::seq_end;
                                end
                            end
                        end
                        default: begin
                            if (!scl) begin  // no ack after the last byte
                                main_state <= eeprom_pkg::main_stop;
                                sub_state  <= eeprom_pkg::seq_begin;
                            end
                        end
                    endcase
                end
                eeprom_pkg::main_ackn: begin
                    if (!scl) begin
                        nack_err   <= 1'b1;
                        main_state <= eeprom_pkg::main_stop;
                        sub_state  <= eeprom_pkg::seq_begin;
                    end
                end
                eeprom_pkg::main_stop: begin
                    case (sub_state)
                        eeprom_pkg::seq_begin: begin
                            if (!scl) begin
                                stop_buf   <= 2'b01;  // hold low first
                                link_stop  <= 1'b1;
                                link_head  <= 1'b0;
                                link_write <= 1'b0;
                                link_sda   <= 1'b1;
                                sub_state  <= eeprom_pkg::seq_bit;
                            end
                        end
                        eeprom_pkg::seq_bit: begin
                            if (scl) begin
                                stop_buf  <= {stop_buf[0], 1'b0};  // rises while scl high
                                sub_state <= eeprom_pkg::seq_end;
                            end
                        end
                        default: begin
                            if (!scl) begin
                                link_sda   <= 1'b0;
                                link_stop  <= 1'b0;
                                done       <= 1'b1;
                                main_state <= eeprom_pkg::main_idle;
                                sub_state  <= eeprom_pkg::seq_begin;
                            end
                        end
                    endcase
                end
                default: main_state <= eeprom_pkg::main_idle;
            endcase
        end
    end

    a_main_onehot: assert property (@(posedge CLK) disable iff (RESET)
        $onehot(main_state));

    // data moves only in the scl low half, start and stop excepted
    a_sda_timing: assert property (@(posedge CLK) disable iff (RESET)
        $changed(m_sda_low) |-> !$past(scl) ||
            $past(main_state) inside {eeprom_pkg::main_write_start,
                                      eeprom_pkg::main_read_start, eeprom_pkg::main_stop});

endmodule

/* src/eeprom_cmd_reg.sv */
`timescale 1ns/1ps
`include "eeprom_config.svh"

module eeprom_cmd_reg (
    input  logic                      CLK,
    input  logic                      RESET,
    input  logic                      wr,
    input  logic                      rd,
    input  logic [`EEPROM_ADDR_W-1:0] addr,
    input  logic [`EEPROM_DATA_W-1:0] wr_data,
    input  logic                      done,
    input  logic [`EEPROM_DATA_W-1:0] rx_byte,
    output logic                      busy,
    output logic                      ack,
    output logic [`EEPROM_DATA_W-1:0] rd_data,
    output logic                      go,
    output eeprom_pkg::op_e           op,
    output logic [`EEPROM_ADDR_W-1:0] cmd_addr,
    output logic [`EEPROM_DATA_W-1:0] cmd_data
);

    logic accept;
    logic done_q;

    // exactly one strobe, and only while idle
    assign accept = (wr ^ rd) & ~busy;

    always_ff @(posedge CLK) begin
        if (RESET) begin
            busy    <= 1'b0;
            go      <= 1'b0;
            done_q  <= 1'b0;
            ack     <= 1'b0;
            rd_data <= '0;
        end else begin
            go     <= accept;
            done_q <= done;
            ack    <= done_q;  // one cycle behind the busy drop
            if (accept) begin
                busy <= 1'b1;
            end else if (done) begin
                busy <= 1'b0;
            end
            if (done && op == eeprom_pkg::op_read) begin
                rd_data <= rx_byte;
            end
        end
    end

    // operands stay put until the next accepted request
    always_ff @(posedge CLK) begin
        if (accept) begin
            op       <= rd ? eeprom_pkg::op_read : eeprom_pkg::op_write;
            cmd_addr <= addr;
            cmd_data <= wr_data;
        end
    end

    a_no_dual_strobe: assert property (@(posedge CLK) disable iff (RESET)
        !(wr && rd));

    // the master only finishes a transfer that was started here
    a_done_while_busy: assert property (@(posedge CLK) disable iff (RESET)
        done |-> busy);

endmodule

/* src/eeprom_pkg.sv */
package eeprom_pkg;

    // master sequence, one-hot
    typedef enum logic [10:0] {
        main_idle        = 11'b000_0000_0001,
        main_ready       = 11'b000_0000_0010,
        main_write_start = 11'b000_0000_0100,
        main_ctrl_write  = 11'b000_0000_1000,
        main_addr_write  = 11'b000_0001_0000,
        main_data_write  = 11'b000_0010_0000,
        main_read_start  = 11'b000_0100_0000,
        main_ctrl_read   = 11'b000_1000_0000,
        main_data_read   = 11'b001_0000_0000,
        main_stop        = 11'b010_0000_0000,
        main_ackn        = 11'b100_0000_0000
    } main_state_e;

    // steps of the start, stop and byte sub-sequences
    typedef enum logic [1:0] {
        seq_begin,
        seq_bit,
        seq_end
    } bit_state_e;

    typedef enum logic {
        op_write = 1'b0,
        op_read  = 1'b1
    } op_e;

    typedef enum logic [2:0] {
        sl_idle,
        sl_get_ctrl,
        sl_get_addr,
        sl_get_data,
        sl_send_data,
        sl_ack_out,
        sl_ack_in
    } slave_state_e;

endpackage

/* src/eeprom_config.svh */
`ifndef EEPROM_CONFIG_SVH
`define EEPROM_CONFIG_SVH

// 2048 x 8 serial memory
`define EEPROM_ADDR_W   11
`define EEPROM_DATA_W   8
`define EEPROM_DEPTH    2048

`define EEPROM_DEV_CODE 4'b1010  // upper nibble of the control byte

`endif
